/* verilog/regBusPkg.sv */
// Chipset register bridge shared definitions.
// CPU request, decoded register command and chipset strobe bundle,
// plus the register window and sequencer state constants.

package regBusPkg;

    ////////////////////////////////////////////////////////////////////////
    // Register window.
    ////////////////////////////////////////////////////////////////////////
    localparam int DATA_W       = 16;               // CPU and chipset word.
    localparam int REG_WIN_BITS = 9;                // A8..A0 inside the window.
    localparam logic [23-REG_WIN_BITS:0] REG_BASE = 15'h6FF8;  // A23..A9 of 0xDFF000.

    // Register cycle states, one per CLK40 step of the chipset cycle.
    localparam logic [2:0] SEQ_IDLE   = 3'd0;     // Wait for req and 68k state 2.
    localparam logic [2:0] SEQ_REGEN  = 3'd1;     // Open register enable.
    localparam logic [2:0] SEQ_WAIT4  = 3'd2;     // Wait for state 4 and DMA grant.
    localparam logic [2:0] SEQ_LATCH  = 3'd3;
    localparam logic [2:0] SEQ_HOLD   = 3'd4;
    localparam logic [2:0] SEQ_SETTLE = 3'd5;     // Read data settling.
    localparam logic [2:0] SEQ_RTACK  = 3'd6;     // Read acknowledge.
    localparam logic [2:0] SEQ_WAIT7  = 3'd7;     // Wait for state 7, then close.

    ////////////////////////////////////////////////////////////////////////
    // Bus bundles.
    ////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [23:0]       addr;     // Byte address.
        logic              rnw;      // High for reads.
        logic              uds;      // Upper byte lane, D15..D8.
        logic              lds;      // Lower byte lane, D7..D0.
        logic [DATA_W-1:0] wdata;
    } cpuReq_t;

    typedef struct packed {
        logic [7:0] regNum;          // Word offset, A8..A1.
        logic       write;
        logic       uds;
        logic       lds;
    } regCmd_t;

    // Strobes toward the chipset and the data path. All active-low ones idle high.
    typedef struct packed {
        logic asN;
        logic regenN;
        logic udsN;
        logic ldsN;
        logic latchReg;              // Write data onto the chipset bus.
        logic regCpuCycle;           // CPU owns the register bus.
    } chipBus_t;

endpackage

/* verilog/regAddrDecode.sv */
// Register window decode.
// Catches CPU transfer starts aimed at the chipset registers and hands
// them to the cycle sequencer over a four-phase req/ack pair.

`timescale 1ns/1ps

module regAddrDecode
    import regBusPkg::*;
(
    input  logic    CLK40,
    input  logic    RESETn,
    input  logic    tsN,
    input  cpuReq_t cpuReq,
    output logic    req,
    input  logic    ack,
    output regCmd_t regCmd
);

    logic hit;
    logic pend;                                      // Hit seen while ack still high.

    // Transfer start inside 0xDFF000..0xDFF1FF.
    assign hit = !tsN && (cpuReq.addr[23:REG_WIN_BITS] == REG_BASE);

    // Command capture. Only while idle so the sequencer sees a stable word.
    always_ff @(posedge CLK40) begin
        if (hit && !req) begin
            regCmd.regNum <= cpuReq.addr[8:1];
            regCmd.write  <= !cpuReq.rnw;
            regCmd.uds    <= cpuReq.uds;
            regCmd.lds    <= cpuReq.lds;
        end
    end

    // Handshake, decode side.
    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            req  <= 1'b0;
            pend <= 1'b0;
        end else begin
            if (req) begin
                if (ack) req <= 1'b0;                // Sequencer has it. Drop req.
            end else if ((hit || pend) && !ack) begin
                req  <= 1'b1;                        // Previous ack gone. Go.
                pend <= 1'b0;
            end else if (hit) begin
                pend <= 1'b1;                        // Hold until ack falls.
            end
        end
    end

    // A new start must not land on a pending request.
    assert property (@(posedge CLK40) disable iff (!RESETn)
        hit |-> !req)
        else $error("Transfer start while req was still high.");

endmodule

/* verilog/regCycleSequencer.sv */
// Chipset register cycle state machine.
// Aligns one register access to the c1/c3 phase clocks, waits out DMA,
// orders the address and data strobes and returns tack to the CPU.
// Writes ack at state 4, reads four clocks later.

`timescale 1ns/1ps

module regCycleSequencer
    import regBusPkg::*;
(
    input  logic       CLK40,
    input  logic       RESETn,
    input  logic       req,
    output logic       ack,
    input  regCmd_t    regCmd,
    input  logic       c1,
    input  logic       c3,
    input  logic       dbrN,
    output chipBus_t   chipBus,
    output logic [8:1] regAddr,
    output logic       tack
);

    logic [1:0] c1Sync;
    logic [1:0] c3Sync;
    logic [1:0] dbrSync;
    logic [2:0] state;
    regCmd_t    cmdQ;                                // Command of the running cycle.
    logic       phase2;
    logic       phase4;
    logic       phase7;
    logic       dmaFree;
    logic       start;

    ////////////////////////////////////////////////////////////////////////////
    // Phase clock and DMA grant synchronizers.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            c1Sync  <= 2'b00;
            c3Sync  <= 2'b00;
            dbrSync <= 2'b00;
        end else begin
            c1Sync  <= {c1Sync[0], c1};
            c3Sync  <= {c3Sync[0], c3};
            dbrSync <= {dbrSync[0], dbrN};
        end
    end

    assign phase2  = !c1Sync[1] &&  c3Sync[1];        // 68k state 2.
    assign phase4  =  c1Sync[1] && !c3Sync[1];        // 68k state 4.
    assign phase7  = !c1Sync[1] && !c3Sync[1];        // 68k state 7.
    assign dmaFree =  dbrSync[1];                     // Low while DMA owns the bus.
    assign start   = req && !ack && phase2;

    assign regAddr = cmdQ.regNum;

    // Hold the command for the whole cycle. Decode drops req early.
    always_ff @(posedge CLK40) begin
        if (state == SEQ_IDLE && start) cmdQ <= regCmd;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register cycle.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            state   <= SEQ_IDLE;
            ack     <= 1'b0;
            tack    <= 1'b0;
            chipBus <= '{asN: 1'b1, regenN: 1'b1, udsN: 1'b1, ldsN: 1'b1,
                         latchReg: 1'b0, regCpuCycle: 1'b0};
        end else begin
            if (ack && !req) ack <= 1'b0;            // Req gone. Close handshake.

            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        chipBus.asN  <= 1'b0;
                        chipBus.udsN <= !(!regCmd.write && regCmd.uds);  // Reads only.
                        chipBus.ldsN <= !(!regCmd.write && regCmd.lds);
                        ack          <= 1'b1;
                        state        <= SEQ_REGEN;
                    end
                end
                SEQ_REGEN: begin
                    chipBus.regenN <= 1'b0;
                    state          <= SEQ_WAIT4;
                end
                SEQ_WAIT4: begin
                    // Write data strobes follow state 4.
                    if (phase4 && cmdQ.uds) chipBus.udsN <= 1'b0;
                    if (phase4 && cmdQ.lds) chipBus.ldsN <= 1'b0;
                    if (phase4 && dmaFree) begin
                        chipBus.regCpuCycle <= 1'b1;
                        tack                <= cmdQ.write;   // Write ack here.
                        state               <= SEQ_LATCH;
                    end
                end
                SEQ_LATCH: begin
                    chipBus.latchReg <= cmdQ.write;
                    tack             <= 1'b0;
                    state            <= SEQ_HOLD;
                end
                SEQ_HOLD: begin
                    chipBus.regCpuCycle <= !cmdQ.write;      // Reads keep the bus.
                    state               <= SEQ_SETTLE;
                end
                SEQ_SETTLE: begin
                    state <= SEQ_RTACK;
                end
                SEQ_RTACK: begin
                    tack  <= !cmdQ.write;                    // Read ack, data is stable.
                    state <= SEQ_WAIT7;
                end
                SEQ_WAIT7: begin
                    tack <= 1'b0;
                    if (phase7) begin
                        chipBus <= '{asN: 1'b1, regenN: 1'b1, udsN: 1'b1, ldsN: 1'b1,
                                     latchReg: 1'b0, regCpuCycle: 1'b0};
                        state   <= SEQ_IDLE;
                    end
                end
            endcase
        end
    end

    // One acknowledge per cycle, one clock wide.
    assert property (@(posedge CLK40) disable iff (!RESETn) tack |=> !tack)
        else $error("tack held longer than one cycle.");

    // Register enable only inside an address strobe.
    assert property (@(posedge CLK40) disable iff (!RESETn)
        !chipBus.regenN |-> !chipBus.asN)
        else $error("regenN low without asN.");

endmodule

/* verilog/regDataPath.sv */
// Register bridge data path.
// Write data held toward the chipset for the cycle. Read data passed to
// the CPU in the read tack cycle with unselected byte lanes forced to zero.

`timescale 1ns/1ps

module regDataPath
    import regBusPkg::*;
(
    input  logic              CLK40,
    input  logic              RESETn,
    input  logic              tsN,
    input  cpuReq_t           cpuReq,
    input  chipBus_t          chipBus,
    input  logic              tack,
    input  logic [DATA_W-1:0] chipRData,
    output logic [DATA_W-1:0] chipWData,
    output logic              chipDataOe,
    output logic [DATA_W-1:0] cpuRData
);

    logic [DATA_W-1:0] wdataQ;
    logic              rnwQ;                         // Transfer direction at tsN.
    logic              udsQ;
    logic              ldsQ;
    logic [DATA_W-1:0] laneMask;
    logic [DATA_W-1:0] rdataQ;                       // Last read word.
    logic              rdTack;                       // Read acknowledge cycle.

    // Write word, taken with the transfer start.
    always_ff @(posedge CLK40) begin
        if (!tsN) wdataQ <= cpuReq.wdata;
    end

    // Lanes and direction for the read capture.
    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            rnwQ <= 1'b0;
            udsQ <= 1'b0;
            ldsQ <= 1'b0;
        end else if (!tsN) begin
            rnwQ <= cpuReq.rnw;
            udsQ <= cpuReq.uds;
            ldsQ <= cpuReq.lds;
        end
    end

    assign laneMask   = {{(DATA_W/2){udsQ}}, {(DATA_W/2){ldsQ}}};
    assign chipWData  = wdataQ;
    assign chipDataOe = chipBus.latchReg;            // Drive only in the latch window.
    assign rdTack     = tack && rnwQ && chipBus.regCpuCycle;

    // Read capture. Held until the next read tack.
    always_ff @(posedge CLK40) begin
        if (rdTack) begin
            rdataQ <= chipRData & laneMask;
        end
    end

    // Word straight through in the tack cycle, held copy afterwards.
    assign cpuRData = rdTack ? (chipRData & laneMask) : rdataQ;

endmodule

/* verilog/regBridgeTop.sv */
// Chipset register bridge top level.
// Decode, cycle sequencer and data path between the CPU bus and the
// custom chip register bus.

`timescale 1ns/1ps

module regBridgeTop
    import regBusPkg::*;
(
    input  logic              CLK40,
    input  logic              RESETn,
    input  logic              tsN,
    input  cpuReq_t           cpuReq,
    output logic              tack,
    output logic [DATA_W-1:0] cpuRData,
    input  logic              c1,
    input  logic              c3,
    input  logic              dbrN,
    output chipBus_t          chipBus,
    output logic [8:1]        regAddr,
    output logic [DATA_W-1:0] chipWData,
    output logic              chipDataOe,
    input  logic [DATA_W-1:0] chipRData
);

    logic    req;                                    // Decode to sequencer handshake.
    logic    ack;
    regCmd_t regCmd;

    regAddrDecode uDecode (
        .CLK40 (CLK40), .RESETn (RESETn), .tsN (tsN), .cpuReq (cpuReq),
        .req (req), .ack (ack), .regCmd (regCmd)
    );

    regCycleSequencer uSeq (
        .CLK40 (CLK40), .RESETn (RESETn), .req (req), .ack (ack), .regCmd (regCmd),
        .c1 (c1), .c3 (c3), .dbrN (dbrN), .chipBus (chipBus), .regAddr (regAddr),
        .tack (tack)
    );

    regDataPath uData (
        .CLK40 (CLK40), .RESETn (RESETn), .tsN (tsN), .cpuReq (cpuReq),
        .chipBus (chipBus), .tack (tack), .chipRData (chipRData),
        .chipWData (chipWData), .chipDataOe (chipDataOe), .cpuRData (cpuRData)
    );

endmodule

/* dv/chipsetModel.sv */
// Behavioral chipset for the register bridge testbench.
// Generates the c1/c3 phase clocks and random DMA bus ownership, and
// holds a 256-word register file that answers the bridge strobes.

`timescale 1ns/1ps

module chipsetModel
    import regBusPkg::*;
(
    input  logic              CLK40,
    input  logic              RESETn,
    input  logic              dmaOn,                 // Enable random DMA stalls.
    output logic              c1,
    output logic              c3,
    output logic              dbrN,
    input  chipBus_t          chipBus,
    input  logic [8:1]        regAddr,
    input  logic [DATA_W-1:0] chipWData,
    input  logic              chipDataOe,
    output logic [DATA_W-1:0] chipRData
);

    localparam int PHASE_LEN = 3;                    // CLK40 cycles per quarter.

    logic [DATA_W-1:0] regFile [256];
    int                phaseCnt;
    int                dmaLeft;                      // Remaining DMA cycles.
    int                gapLeft;                      // Free cycles before next stall.

    ////////////////////////////////////////////////////////////////////////////
    // Phase clocks. Quadrature, state 2 first.
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge CLK40) begin
        if (!RESETn) phaseCnt <= 0;
        else phaseCnt <= (phaseCnt == 4 * PHASE_LEN - 1) ? 0 : phaseCnt + 1;
    end

    assign c3 = (phaseCnt < 2 * PHASE_LEN);          // Quarters 0 and 1.
    assign c1 = (phaseCnt >= PHASE_LEN) && (phaseCnt < 3 * PHASE_LEN);

    ////////////////////////////////////////////////////////////////////////////
    // DMA ownership. Random stretches low, random gaps high.
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge CLK40) begin
        if (!RESETn) begin
            dbrN    <= 1'b1;
            dmaLeft <= 0;
            gapLeft <= 8;
        end else if (!dbrN) begin
            if (dmaLeft == 0) begin
                dbrN    <= 1'b1;                     // DMA done. Bus back to CPU.
                gapLeft <= 3 + ($urandom % 12);
            end else begin
                dmaLeft <= dmaLeft - 1;
            end
        end else if (gapLeft > 0) begin
            gapLeft <= gapLeft - 1;
        end else if (dmaOn) begin
            dbrN    <= 1'b0;
            dmaLeft <= $urandom % 10;
        end
    end

    // Register file. Fill on reset, byte writes through the data strobes.
    always @(posedge CLK40) begin
        if (!RESETn) begin
            for (int i = 0; i < 256; i++) regFile[i] <= {i[7:0], ~i[7:0]};
        end else if (!chipBus.regenN && chipDataOe) begin
            if (!chipBus.udsN) regFile[regAddr][15:8] <= chipWData[15:8];
            if (!chipBus.ldsN) regFile[regAddr][7:0]  <= chipWData[7:0];
        end
    end

    assign chipRData = regFile[regAddr];             // Whole word. Bridge masks lanes.

endmodule

/* dv/regBridgeTb.sv */
// Register bridge testbench.
// Applies a table of CPU transfers against the behavioral chipset and
// checks tack, read data, chipset strobes and the register file.

`timescale 1ns/1ps

module regBridgeTb
    import regBusPkg::*;
();

    // One row. For writes and misses expData is the register afterwards.
    typedef struct packed {
        logic [23:0]       addr;
        logic              rnw;
        logic              uds;
        logic              lds;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] expData;
        logic              expTack;
        logic              dma;                      // Random DMA stalls on.
    } stim_t;

    localparam int NUM_ROWS = 16;
    localparam int TIMEOUT  = 400;                   // Clocks per wait.
    localparam int MISS_WIN = 64;
    localparam chipBus_t IDLE_BUS = '{asN: 1'b1, regenN: 1'b1, udsN: 1'b1, ldsN: 1'b1,
                                      latchReg: 1'b0, regCpuCycle: 1'b0};

    // Register file fill is {regNum, ~regNum}.
    localparam stim_t STIM [NUM_ROWS] = '{
        //  addr        rnw   uds   lds   wdata     expData   tack  dma
        '{24'hDFF040, 1'b0, 1'b1, 1'b1, 16'h1234, 16'h1234, 1'b1, 1'b0},
        '{24'hDFF042, 1'b0, 1'b1, 1'b0, 16'hAB99, 16'hABDE, 1'b1, 1'b0},
        '{24'hDFF044, 1'b0, 1'b0, 1'b1, 16'h77CD, 16'h22CD, 1'b1, 1'b0},
        '{24'hDFF040, 1'b1, 1'b1, 1'b1, 16'h0000, 16'h1234, 1'b1, 1'b0},
        '{24'hDFF042, 1'b1, 1'b1, 1'b0, 16'h0000, 16'hAB00, 1'b1, 1'b0},
        '{24'hDFF044, 1'b1, 1'b0, 1'b1, 16'h0000, 16'h00CD, 1'b1, 1'b0},
        '{24'hDFF1FE, 1'b1, 1'b1, 1'b1, 16'h0000, 16'hFF00, 1'b1, 1'b0},
        '{24'hDFE040, 1'b0, 1'b1, 1'b1, 16'hDEAD, 16'h1234, 1'b0, 1'b0},  // Below window.
        '{24'hDFF200, 1'b1, 1'b1, 1'b1, 16'h0000, 16'h00FF, 1'b0, 1'b0},  // Above window.
        '{24'hDFF000, 1'b0, 1'b1, 1'b1, 16'hC0DE, 16'hC0DE, 1'b1, 1'b1},
        '{24'hDFF000, 1'b1, 1'b1, 1'b1, 16'h0000, 16'hC0DE, 1'b1, 1'b1},
        '{24'hDFF17E, 1'b0, 1'b0, 1'b1, 16'h5511, 16'hBF11, 1'b1, 1'b1},
        '{24'hDFF17E, 1'b1, 1'b1, 1'b1, 16'h0000, 16'hBF11, 1'b1, 1'b1},
        '{24'hDFF0A0, 1'b1, 1'b1, 1'b0, 16'h0000, 16'h5000, 1'b1, 1'b1},
        '{24'hDFE0A0, 1'b0, 1'b1, 1'b1, 16'hBEEF, 16'h50AF, 1'b0, 1'b1},
        '{24'hDFF0A0, 1'b0, 1'b1, 1'b1, 16'h0F0F, 16'h0F0F, 1'b1, 1'b1}
    };

    logic              CLK40;
    logic              RESETn;
    logic              tsN;
    cpuReq_t           cpuReq;
    logic              tack;
    logic [DATA_W-1:0] cpuRData;
    logic              c1;
    logic              c3;
    logic              dbrN;
    chipBus_t          chipBus;
    logic [8:1]        regAddr;
    logic [DATA_W-1:0] chipWData;
    logic              chipDataOe;
    logic [DATA_W-1:0] chipRData;
    logic              dmaOn;
    logic              curWrite;                     // Direction of the running row.
    logic [2:0]        phaseHist [8];                // {c1, c3, dbrN}, newest first.

    regBridgeTop dut (.*);
    chipsetModel model (.*);

    initial begin
        CLK40 = 1'b0;
        forever #50 CLK40 = ~CLK40;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks.
    ////////////////////////////////////////////////////////////////////////////
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Stopped at first error.");
    endtask

    task automatic checkData(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] want);
        if (got !== want)
            abortRun($sformatf("CHECK FAILED at %0t: %s expected %h, got %h",
                               $time, name, want, got));
    endtask

    task automatic checkCmd(input string name, input regCmd_t got, input regCmd_t want);
        if (got !== want)
            abortRun($sformatf("CHECK FAILED at %0t: %s expected %h/%b%b%b, got %h/%b%b%b",
                               $time, name, want.regNum, want.write, want.uds, want.lds,
                               got.regNum, got.write, got.uds, got.lds));
    endtask

    task automatic checkIdle(input string name, input chipBus_t got);
        if (got !== IDLE_BUS)
            abortRun($sformatf("CHECK FAILED at %0t: %s expected %b, got %b",
                               $time, name, IDLE_BUS, got));
    endtask

    // Tack must trail state 4 with DMA grant by the two-flop synchronizer,
    // writes right away, reads four clocks later.
    always @(negedge CLK40) begin
        for (int i = 7; i > 0; i--) phaseHist[i] = phaseHist[i - 1];
        phaseHist[0] = {c1, c3, dbrN};
        if (RESETn && tack && phaseHist[curWrite ? 3 : 7] !== 3'b101)
            abortRun($sformatf("tack at %0t did not follow state 4 with DMA granted.", $time));
    end

    ////////////////////////////////////////////////////////////////////////////
    // One table row.
    ////////////////////////////////////////////////////////////////////////////
    task automatic runRow(input stim_t s);
        regCmd_t seen;
        regCmd_t want;
        logic    drove;
        logic    gotTack;
        int      n;
        want    = '{regNum: s.addr[8:1], write: !s.rnw, uds: s.uds, lds: s.lds};
        seen    = '0;
        drove   = 1'b0;
        gotTack = 1'b0;
        n       = 0;
        @(posedge CLK40);
        curWrite <= !s.rnw;
        dmaOn    <= s.dma;
        cpuReq   <= '{addr: s.addr, rnw: s.rnw, uds: s.uds, lds: s.lds, wdata: s.wdata};
        tsN      <= 1'b0;
        @(posedge CLK40);
        tsN      <= 1'b1;
        if (!s.expTack) begin
            for (n = 0; n < MISS_WIN; n++) begin  // Miss. Bus must stay quiet.
                @(negedge CLK40);
                if (tack) abortRun($sformatf("tack given for %h outside the window.", s.addr));
                if (!chipBus.asN) abortRun($sformatf("asN fell for %h outside the window.", s.addr));
            end
            checkData("regFile", model.regFile[s.addr[8:1]], s.expData);
        end else begin
            while (!gotTack) begin
                @(negedge CLK40);
                n++;
                if (n > TIMEOUT) abortRun($sformatf("No tack for %h in time.", s.addr));
                drove   = drove | chipDataOe;
                gotTack = tack;
            end
            seen = '{regNum: regAddr, write: 1'b0, uds: !chipBus.udsN, lds: !chipBus.ldsN};
            if (s.rnw) checkData("cpuRData", cpuRData, s.expData);   // Valid with tack.
            n = 0;
            while (chipBus.asN !== 1'b1) begin      // Cycle end at state 7.
                @(negedge CLK40);
                n++;
                if (n > TIMEOUT) abortRun($sformatf("Cycle for %h never closed.", s.addr));
                if (tack) abortRun($sformatf("Second tack for %h.", s.addr));
                drove = drove | chipDataOe;
            end
            seen.write = drove;
            checkCmd("regCmd", seen, want);
            checkIdle("chipBus", chipBus);
            if (s.rnw) checkData("cpuRData", cpuRData, s.expData);   // Held after the cycle.
            else checkData("regFile", model.regFile[s.addr[8:1]], s.expData);
        end
    endtask

    initial begin
        void'($urandom(53066));                     // Model stalls draw from here.
        RESETn   = 1'b0;
        tsN      = 1'b1;
        cpuReq   = '0;
        dmaOn    = 1'b0;
        curWrite = 1'b0;
        repeat (10) @(posedge CLK40);
        RESETn <= 1'b1;
        for (int i = 0; i < 16; i++) begin          // Quiet bus after reset.
            @(negedge CLK40);
            checkIdle("chipBus", chipBus);
            if (tack) abortRun("tack high with no transfer after reset.");
        end
        for (int r = 0; r < NUM_ROWS; r++) runRow(STIM[r]);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* all.f */
verilog/regBusPkg.sv
verilog/regAddrDecode.sv
verilog/regCycleSequencer.sv
verilog/regDataPath.sv
verilog/regBridgeTop.sv
dv/chipsetModel.sv
dv/regBridgeTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the chipset register bridge testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=regBridgeSim
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module regBridgeTb -Mdir "$BUILD_DIR" -o "$SIM_BIN" -f all.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus."
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"

if grep -q "TESTS FAILED" "$LOG_FILE"; then
    echo "Simulation reported failure."
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus."
    exit 1
fi
exit 0
